//--- Bender.yml
package:
  name: qic_streamer

sources:
  # RTL, package first
  - src/qic_pkg.sv
  - src/qic_bit_front.sv
  - src/qic_block_framer.sv
  - src/qic_block_tally.sv
  - src/qic_streamer_top.sv
  # Testbench
  - target: test
    files:
      - verif/qic_stream_checker.sv
      - verif/tb_qic_streamer.sv

//--- src/qic_bit_front.sv
/* One bit per rising edge of mfm_clock, which must stay high for at least 1 clk
   Hit flags describe the window including the current bit, valid with bit_stb only */

`timescale 1ns/1ns
`default_nettype none

module qic_bit_front (
    input  wire  clk,
    input  wire  reset_n,
    input  wire  enable,        // Streamer enable
    input  wire  streaming,     // Tape moving
    input  wire  mfm_data,      // Recovered bit
    input  wire  mfm_clock,     // Bit strobe, level
    output logic bit_stb,       // New bit, 1 clk
    output logic bit_val,
    output logic preamble_hit,
    output logic sync_hit,
    output logic halt           // Path inactive
);
    import qic_pkg::*;

    logic        mfm_clock_q;  // Previous strobe sample
    mfm_window_t window;
    mfm_window_t window_next;  // Window with the current bit shifted in

    // ==============================
    // Strobe edge and gating
    // ==============================
    assign halt    = !enable || !streaming;
    assign bit_stb = mfm_clock && !mfm_clock_q && !halt;
    assign bit_val = mfm_data;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mfm_clock_q <= 1'b0;
        end else begin
            mfm_clock_q <= mfm_clock;
        end
    end

    // ==============================
    // Pattern window
    // ==============================
    assign window_next = {window[14:0], mfm_data};

    // Either preamble phase is accepted
    assign preamble_hit = bit_stb && ((window_next == PREAMBLE_WORD) ||
                                      (window_next == PREAMBLE_WORD_INV));
    assign sync_hit     = bit_stb && (window_next == SYNC_WORD);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            window <= '0;
        end else if (halt) begin
            window <= '0;                  // Stale bits never match later
        end else if (bit_stb) begin
            window <= window_next;
        end
    end

endmodule

`default_nettype wire

//--- src/qic_block_framer.sv
/* Bits are ignored while dpll_locked is low; lock loss inside a block aborts it
   Outputs follow the last bit of a byte by 1 clk; type flags hold until the gap */

`timescale 1ns/1ns
`default_nettype none

module qic_block_framer (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                halt,            // Path inactive, back to hunt
    input  wire                bit_stb,
    input  wire                bit_val,
    input  wire                preamble_hit,
    input  wire                sync_hit,
    input  wire                dpll_locked,
    output logic               block_sync,      // Sync mark accepted
    output logic               block_start,     // Header byte done
    output logic               block_complete,  // Last ECC byte done
    output logic               frame_error,
    output logic               preamble_error,
    output logic               sync_lost,
    output qic_pkg::byte_t     data_byte,
    output logic               data_valid,
    output logic               data_is_header,
    output logic               data_is_ecc,
    output qic_pkg::byte_pos_t byte_in_block,
    output qic_pkg::byte_t     block_header,
    output qic_pkg::ecc_t      ecc_bytes,
    output logic               ecc_valid,
    output logic               is_data_block,
    output logic               is_file_mark,
    output logic               is_eod_mark,
    output logic               is_bad_block
);
    import qic_pkg::*;

    typedef enum logic [2:0] {
        ST_HUNT, ST_PREAMBLE, ST_SYNC_CHECK, ST_HEADER, ST_DATA, ST_ECC, ST_GAP
    } state_t;

    state_t    state;
    logic [2:0] bit_cnt;     // Bit within byte
    logic [3:0] pre_cnt;     // Counted preamble bytes, saturating
    byte_pos_t byte_cnt;     // Data byte, then ECC byte index
    logic [6:0] byte_shift;  // Earlier bits of the byte
    byte_t     byte_next;
    logic      accept;       // Bit taken this cycle
    logic      byte_end;
    logic      in_block;

    assign accept      = bit_stb && dpll_locked && !halt;
    assign byte_end    = (bit_cnt == 3'd7);
    assign byte_next   = {byte_shift, bit_val};
    assign in_block    = (state == ST_HEADER) || (state == ST_DATA) || (state == ST_ECC);
    assign frame_error = preamble_error || sync_lost;

    // ==============================
    // Block state machine
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state          <= ST_HUNT;
            bit_cnt        <= '0;
            pre_cnt        <= '0;
            byte_cnt       <= '0;
            block_sync     <= 1'b0;
            block_start    <= 1'b0;
            block_complete <= 1'b0;
            preamble_error <= 1'b0;
            sync_lost      <= 1'b0;
            data_valid     <= 1'b0;
            data_is_header <= 1'b0;
            data_is_ecc    <= 1'b0;
            ecc_valid      <= 1'b0;
            is_data_block  <= 1'b0;
            is_file_mark   <= 1'b0;
            is_eod_mark    <= 1'b0;
            is_bad_block   <= 1'b0;
        end else begin
            // Strobes default low
            block_sync     <= 1'b0;
            block_start    <= 1'b0;
            block_complete <= 1'b0;
            preamble_error <= 1'b0;
            sync_lost      <= 1'b0;
            data_valid     <= 1'b0;
            data_is_header <= 1'b0;
            data_is_ecc    <= 1'b0;
            ecc_valid      <= 1'b0;
            if (halt) begin
                state   <= ST_HUNT;               // Stream drop, no error
                bit_cnt <= '0;
            end else if (in_block && !dpll_locked) begin
                sync_lost <= 1'b1;
                state     <= ST_HUNT;
            end else if (accept) begin
                bit_cnt <= bit_cnt + 3'd1;        // Wraps every byte
                case (state)
                    ST_HUNT: begin
                        if (preamble_hit) begin
                            pre_cnt <= 4'd1;
                            bit_cnt <= '0;
                            state   <= ST_PREAMBLE;
                        end
                    end
                    ST_PREAMBLE: begin
                        if (byte_end && preamble_hit && (pre_cnt != '1)) begin
                            pre_cnt <= pre_cnt + 4'd1;
                        end
                        if (sync_hit) begin
                            bit_cnt <= '0;        // Next bit opens the 0xA1 byte
                            if (pre_cnt >= PREAMBLE_MIN) begin
                                block_sync <= 1'b1;
                                state      <= ST_SYNC_CHECK;
                            end else begin
                                preamble_error <= 1'b1;
                                state          <= ST_HUNT;
                            end
                        end
                    end
                    ST_SYNC_CHECK: begin
                        if (byte_end) begin
                            state <= (byte_next == SYNC_BYTE) ? ST_HEADER : ST_HUNT;
                        end
                    end
                    ST_HEADER: begin
                        if (byte_end) begin
                            data_valid     <= 1'b1;
                            data_is_header <= 1'b1;
                            block_start    <= 1'b1;
                            is_data_block  <= (byte_next == HDR_DATA);
                            is_file_mark   <= (byte_next == HDR_FILE_MARK);
                            is_eod_mark    <= (byte_next == HDR_EOD);
                            is_bad_block   <= (byte_next == HDR_BAD);
                            byte_cnt       <= '0;
                            state          <= ST_DATA;
                        end
                    end
                    ST_DATA: begin
                        if (byte_end) begin
                            data_valid <= 1'b1;
                            byte_cnt   <= byte_cnt + 9'd1;    // Wraps to 0 for ECC
                            if (byte_cnt == byte_pos_t'(DATA_BYTES - 1)) begin
                                state <= ST_ECC;
                            end
                        end
                    end
                    ST_ECC: begin
                        if (byte_end) begin
                            data_valid  <= 1'b1;
                            data_is_ecc <= 1'b1;
                            byte_cnt    <= byte_cnt + 9'd1;
                            if (byte_cnt == byte_pos_t'(ECC_BYTES - 1)) begin
                                ecc_valid      <= 1'b1;
                                block_complete <= 1'b1;
                                state          <= ST_GAP;
                            end
                        end
                    end
                    default: begin                // Inter-block gap
                        is_data_block <= 1'b0;
                        is_file_mark  <= 1'b0;
                        is_eod_mark   <= 1'b0;
                        is_bad_block  <= 1'b0;
                        state         <= ST_HUNT;
                    end
                endcase
            end
        end
    end

    // ==============================
    // Byte payload
    // ==============================
    always_ff @(posedge clk) begin
        if (accept) begin
            byte_shift <= byte_next[6:0];
            if (byte_end && in_block) begin
                data_byte <= byte_next;
                case (state)
                    ST_HEADER: begin
                        block_header  <= byte_next;
                        byte_in_block <= '0;
                    end
                    ST_DATA: byte_in_block <= byte_cnt;
                    default: ecc_bytes[8*byte_cnt[1:0] +: 8] <= byte_next;  // Byte 0 low
                endcase
            end
        end
    end

    // Tags only ever mark a valid byte, never both at once
    a_tags_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(data_is_header && data_is_ecc));
    a_tag_has_valid: assert property (@(posedge clk) disable iff (!reset_n)
        (data_is_header || data_is_ecc) |-> data_valid);

endmodule

`default_nettype wire

//--- src/qic_block_tally.sv
/* Counters wrap at 16 bits; clear_counters wins over a same-cycle increment
   Segment position survives a clear and moves only on completed blocks */

`timescale 1ns/1ns
`default_nettype none

module qic_block_tally (
    input  wire               clk,
    input  wire               reset_n,
    input  wire               clear_counters,
    input  wire               block_start,
    input  wire               block_complete,
    input  wire               frame_error,
    output qic_pkg::blk_idx_t block_in_segment,
    output logic              segment_start,
    output logic              segment_complete,
    output qic_pkg::count_t   segment_count,
    output qic_pkg::count_t   good_block_count,
    output qic_pkg::count_t   error_count
);
    import qic_pkg::*;

    logic last_block;   // Index at segment end

    // ==============================
    // Segment position
    // ==============================
    assign last_block       = (block_in_segment == blk_idx_t'(BLOCKS_PER_SEG - 1));
    assign segment_start    = block_start && (block_in_segment == '0);
    assign segment_complete = block_complete && last_block;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            block_in_segment <= '0;
        end else if (block_complete) begin
            block_in_segment <= last_block ? '0 : block_in_segment + 5'd1;
        end
    end

    // ==============================
    // Status counters
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            segment_count    <= '0;
            good_block_count <= '0;
            error_count      <= '0;
        end else if (clear_counters) begin
            segment_count    <= '0;
            good_block_count <= '0;
            error_count      <= '0;
        end else begin
            if (block_complete) good_block_count <= good_block_count + 16'd1; // Any type
            if (segment_complete) segment_count <= segment_count + 16'd1;
            if (frame_error) error_count <= error_count + 16'd1;
        end
    end

    // Segment end is a block end and restarts the position
    a_seg_wrap: assert property (@(posedge clk) disable iff (!reset_n)
        segment_complete |-> block_complete ##1 (block_in_segment == '0));

endmodule

`default_nettype wire

//--- src/qic_pkg.sv
/* QIC-117 block format constants and shared widths
   Segment handling assumes BLOCKS_PER_SEG fits blk_idx_t */

`default_nettype none

package qic_pkg;

    // ==============================
    // Widths
    // ==============================
    typedef logic [7:0]  byte_t;       // One tape byte
    typedef logic [8:0]  byte_pos_t;   // Data byte position 0..511
    typedef logic [4:0]  blk_idx_t;    // Block within segment
    typedef logic [15:0] count_t;      // Status counters
    typedef logic [23:0] ecc_t;        // Three ECC bytes, byte 0 low
    typedef logic [15:0] mfm_window_t; // Pattern window

    // ==============================
    // Block format
    // ==============================
    localparam int PREAMBLE_MIN   = 6;   // Counted preamble bytes needed
    localparam int DATA_BYTES     = 512; // Payload per block
    localparam int ECC_BYTES      = 3;   // Trailing ECC
    localparam int BLOCKS_PER_SEG = 32;  // 16 KB segment

    // Sync mark, missing clock form of 0xA1
    localparam mfm_window_t SYNC_WORD = 16'h4489;
    localparam byte_t SYNC_BYTE = 8'hA1;     // Second half of the mark

    // Alternating run, either phase
    localparam mfm_window_t PREAMBLE_WORD     = 16'hAAAA;
    localparam mfm_window_t PREAMBLE_WORD_INV = 16'h5555;

    // ==============================
    // Header byte codes
    // ==============================
    localparam byte_t HDR_DATA      = 8'h00; // Normal data
    localparam byte_t HDR_EOD       = 8'h0F; // End of recorded data
    localparam byte_t HDR_FILE_MARK = 8'h1F; // File separator
    localparam byte_t HDR_BAD       = 8'hFF; // Mapped-out block

endpackage

`default_nettype wire

//--- src/qic_streamer_top.sv
/* QIC-117 block streamer, serial bit stream in, tagged byte stream out
   Byte output lags its last bit by 1 clk; the tape cannot be stalled */

`timescale 1ns/1ns
`default_nettype none

module qic_streamer_top (
    input  wire                clk,
    input  wire                reset_n,
    input  wire                enable,
    input  wire                streaming,
    input  wire                clear_counters,
    input  wire                mfm_data,
    input  wire                mfm_clock,
    input  wire                dpll_locked,
    output logic               block_sync,
    output logic               block_start,
    output logic               block_complete,
    output logic               preamble_error,
    output logic               sync_lost,
    output qic_pkg::byte_t     data_byte,
    output logic               data_valid,
    output logic               data_is_header,
    output logic               data_is_ecc,
    output qic_pkg::byte_pos_t byte_in_block,
    output qic_pkg::byte_t     block_header,
    output qic_pkg::ecc_t      ecc_bytes,
    output logic               ecc_valid,
    output logic               is_data_block,
    output logic               is_file_mark,
    output logic               is_eod_mark,
    output logic               is_bad_block,
    output qic_pkg::blk_idx_t  block_in_segment,
    output logic               segment_start,
    output logic               segment_complete,
    output qic_pkg::count_t    segment_count,
    output qic_pkg::count_t    good_block_count,
    output qic_pkg::count_t    error_count
);
    // Front end to framer
    logic bit_stb;
    logic bit_val;
    logic preamble_hit;
    logic sync_hit;
    logic halt;
    logic frame_error;   // Framer to tally

    qic_bit_front u_front (
        .clk, .reset_n, .enable, .streaming, .mfm_data, .mfm_clock,
        .bit_stb, .bit_val, .preamble_hit, .sync_hit, .halt
    );

    qic_block_framer u_framer (
        .clk, .reset_n, .halt, .bit_stb, .bit_val, .preamble_hit, .sync_hit, .dpll_locked,
        .block_sync, .block_start, .block_complete, .frame_error, .preamble_error,
        .sync_lost, .data_byte, .data_valid, .data_is_header, .data_is_ecc,
        .byte_in_block, .block_header, .ecc_bytes, .ecc_valid,
        .is_data_block, .is_file_mark, .is_eod_mark, .is_bad_block
    );

    qic_block_tally u_tally (
        .clk, .reset_n, .clear_counters, .block_start, .block_complete, .frame_error,
        .block_in_segment, .segment_start, .segment_complete,
        .segment_count, .good_block_count, .error_count
    );

endmodule

`default_nettype wire

//--- verif/qic_stream_checker.sv
/* Compares bytes, tags, type flags, ECC and strobe totals with queued expectations
   Samples the DUT on the falling clk edge, half a cycle after its registers move */

`timescale 1ns/1ns
`default_nettype none

module qic_stream_checker (
    input wire        clk,
    input wire        reset_n,
    input wire        block_sync,
    input wire        block_start,
    input wire        block_complete,
    input wire [7:0]  data_byte,
    input wire        data_valid,
    input wire        data_is_header,
    input wire        data_is_ecc,
    input wire [8:0]  byte_in_block,
    input wire [7:0]  block_header,
    input wire [23:0] ecc_bytes,
    input wire        ecc_valid,
    input wire        is_data_block,
    input wire        is_file_mark,
    input wire        is_eod_mark,
    input wire        is_bad_block,
    input wire        preamble_error,
    input wire        sync_lost,
    input wire        segment_start,
    input wire        segment_complete,
    input wire [4:0]  block_in_segment,
    input wire [15:0] segment_count,
    input wire [15:0] good_block_count,
    input wire [15:0] error_count
);
    import qic_pkg::*;

    logic [9:0]  byte_q [$];   // Header tag, ECC tag, byte
    logic [23:0] ecc_q [$];
    int errors = 0;
    int bytes_seen = 0;
    int data_pos = 0;          // Next data byte position in the block
    int pre_errs = 0, lock_losses = 0, seg_starts = 0, seg_ends = 0;
    int syncs_seen = 0, starts_seen = 0, dones_seen = 0;

    // One flag per header code, order as on the ports
    function automatic logic [3:0] flags_for(input logic [7:0] hdr);
        return {hdr == HDR_DATA, hdr == HDR_FILE_MARK, hdr == HDR_EOD, hdr == HDR_BAD};
    endfunction

    task automatic queue_byte(input logic [7:0] b, input logic hdr, input logic ecc);
        byte_q.push_back({hdr, ecc, b});
    endtask

    task automatic await_ecc(input logic [23:0] v);
        ecc_q.push_back(v);
    endtask

    // ==============================
    // Byte stream
    // ==============================
    task automatic match_byte();
        logic [9:0] exp;
        if (byte_q.size() == 0) begin
            errors++;
            $display("Error %0t: unexpected byte %h on data_valid", $time, data_byte);
            return;
        end
        exp = byte_q.pop_front();
        bytes_seen++;
        if ({data_is_header, data_is_ecc, data_byte} !== exp) begin
            errors++;
            $display("Error %0t: byte %h tags %b%b, expected %h tags %b%b", $time,
                     data_byte, data_is_header, data_is_ecc, exp[7:0], exp[9], exp[8]);
        end
        // Flags land with the header byte
        if (exp[9] && ({is_data_block, is_file_mark, is_eod_mark, is_bad_block} !==
                       flags_for(exp[7:0]))) begin
            errors++;
            $display("Error %0t: type flags %b after header %h", $time,
                     {is_data_block, is_file_mark, is_eod_mark, is_bad_block}, exp[7:0]);
        end
        if (exp[9]) begin
            data_pos = 0;              // Payload numbering restarts
            if (block_header !== exp[7:0]) begin
                errors++;
                $display("Error %0t: block_header %h, expected %h", $time,
                         block_header, exp[7:0]);
            end
        end else if (!exp[8]) begin
            if (byte_in_block !== data_pos[8:0]) begin
                errors++;
                $display("Error %0t: byte_in_block %0d, expected %0d", $time,
                         byte_in_block, data_pos);
            end
            data_pos++;
        end
    endtask

    task automatic verify_ecc();
        logic [23:0] exp;
        if (ecc_q.size() == 0) begin
            errors++;
            $display("Error %0t: ecc_valid with no block expected", $time);
            return;
        end
        exp = ecc_q.pop_front();
        if (ecc_bytes !== exp) begin
            errors++;
            $display("Error %0t: ecc_bytes %h, expected %h", $time, ecc_bytes, exp);
        end
    endtask

    always @(negedge clk) begin
        if (reset_n) begin
            if (preamble_error) pre_errs++;
            if (sync_lost) lock_losses++;
            if (segment_start) seg_starts++;
            if (segment_complete) seg_ends++;
            if (block_sync) syncs_seen++;
            if (block_start) starts_seen++;
            if (block_complete) dones_seen++;
            if (data_valid) match_byte();
            if (ecc_valid) verify_ecc();
        end
    end

    // ==============================
    // Counters and totals
    // ==============================
    task automatic audit_counters(input int good, input int seg, input int err, input int idx);
        if (good_block_count !== good[15:0] || segment_count !== seg[15:0] ||
            error_count !== err[15:0] || block_in_segment !== idx[4:0]) begin
            errors++;
            $display("Error %0t: good/seg/err/idx %0d %0d %0d %0d, expected %0d %0d %0d %0d",
                     $time, good_block_count, segment_count, error_count, block_in_segment,
                     good, seg, err, idx);
        end
    endtask

    // Preamble errors, lock losses, segment starts, segment ends
    task automatic strobe_totals(input int pre, input int lost, input int starts, input int ends);
        if (pre_errs != pre || lock_losses != lost || seg_starts != starts ||
            seg_ends != ends) begin
            errors++;
            $display("Error %0t: pulses %0d %0d %0d %0d, expected %0d %0d %0d %0d",
                     $time, pre_errs, lock_losses, seg_starts, seg_ends, pre, lost, starts, ends);
        end
    endtask

    // Sync accepts, block starts, block completions
    task automatic frame_totals(input int syncs, input int starts, input int dones);
        if (syncs_seen != syncs || starts_seen != starts || dones_seen != dones) begin
            errors++;
            $display("Error %0t: block pulses %0d %0d %0d, expected %0d %0d %0d",
                     $time, syncs_seen, starts_seen, dones_seen, syncs, starts, dones);
        end
    endtask

    task automatic close_out();
        if (byte_q.size() != 0 || ecc_q.size() != 0) begin
            errors++;
            $display("Output missing: %0d bytes and %0d ECC words never appeared",
                     byte_q.size(), ecc_q.size());
        end
        $display("Checker totals: %0d bytes, %0d preamble errors, %0d lock losses, %0d errors",
                 bytes_seen, pre_errs, lock_losses, errors);
    endtask

endmodule

`default_nettype wire

//--- verif/tb_qic_streamer.sv
/* Plays table rows as serial QIC blocks, one bit per 4 clk, MSB first
   Expected bytes and counters come from a format model kept in this module */

`timescale 1ns/1ns
`default_nettype none

module tb_qic_streamer;
    import qic_pkg::*;

    localparam int NUM_ROWS = 10;
    localparam logic [1:0] F_NONE   = 2'd0;  // Clean block
    localparam logic [1:0] F_SHORT  = 2'd1;  // Preamble too short
    localparam logic [1:0] F_LOCK   = 2'd2;  // DPLL drop at data byte
    localparam logic [1:0] F_STREAM = 2'd3;  // Tape stop at data byte

    typedef struct packed {
        logic [7:0]  pre_len;   // 0xAA bytes
        logic [7:0]  hdr;
        logic [23:0] ecc;       // Byte 0 low, sent first
        logic [1:0]  fault;
        logic [9:0]  fault_at;  // Data bytes sent before the fault
        logic [7:0]  reps;
    } row_t;

    row_t        rows [NUM_ROWS];
    logic [31:0] seed = 32'd24;
    longint      wd_limit;
    logic        wd_armed = 1'b0;
    int exp_good = 0, exp_seg = 0, exp_err = 0, exp_idx = 0;   // Model counters
    int exp_pre_err = 0, exp_sync_lost = 0, exp_seg_start = 0, exp_seg_done = 0;
    int exp_framed = 0;   // Blocks past the sync mark

    logic clk = 1'b0;
    logic reset_n, enable, streaming, clear_counters, mfm_data, mfm_clock, dpll_locked;
    logic block_sync, block_start, block_complete, preamble_error, sync_lost;
    logic data_valid, data_is_header, data_is_ecc, ecc_valid, segment_start, segment_complete;
    logic is_data_block, is_file_mark, is_eod_mark, is_bad_block;
    logic [7:0]  data_byte, block_header;
    logic [8:0]  byte_in_block;
    logic [23:0] ecc_bytes;
    logic [4:0]  block_in_segment;
    logic [15:0] segment_count, good_block_count, error_count;

    qic_streamer_top dut0 (.*);
    qic_stream_checker chk0 (.*);

    always #20 clk = ~clk;   // 40 ns period

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic load_table();
        // pre_len, header, ECC, fault, fault byte, repeats
        rows[0] = {8'd8,  HDR_DATA,      24'h3C5A96, F_NONE,   10'd0,   8'd1};
        rows[1] = {8'd10, HDR_FILE_MARK, 24'h0F1E2D, F_NONE,   10'd0,   8'd1};
        rows[2] = {8'd7,  HDR_EOD,       24'h123456, F_NONE,   10'd0,   8'd1};
        rows[3] = {8'd12, HDR_BAD,       24'h9ABCDE, F_NONE,   10'd0,   8'd1};
        rows[4] = {8'd4,  HDR_DATA,      24'h000000, F_SHORT,  10'd0,   8'd1};
        rows[5] = {8'd8,  HDR_DATA,      24'h000000, F_LOCK,   10'd100, 8'd1};
        rows[6] = {8'd8,  HDR_DATA,      24'h2468AC, F_NONE,   10'd0,   8'd1};
        rows[7] = {8'd9,  HDR_DATA,      24'h000000, F_STREAM, 10'd200, 8'd1};
        rows[8] = {8'd8,  HDR_DATA,      24'h778899, F_NONE,   10'd0,   8'd1};
        rows[9] = {8'd7,  HDR_DATA,      24'hE1C3A5, F_NONE,   10'd0,   8'd27};  // Reaches 33
    endtask

    // Strobe high 2 clk, low 2 clk per bit; entered 2 ns after a rising edge
    task automatic shift_byte(input logic [7:0] b);
        int i;
        for (i = 7; i >= 0; i--) begin
            mfm_data  = b[i];
            mfm_clock = 1'b1;
            repeat (2) @(posedge clk);
            #2;
            mfm_clock = 1'b0;
            repeat (2) @(posedge clk);
            #2;
        end
    endtask

    task automatic abort_block(input logic [1:0] fault);
        if (fault == F_LOCK) begin
            dpll_locked = 1'b0;
            exp_err++;
            exp_sync_lost++;
            shift_byte(8'h00);          // Ignored while unlocked
            dpll_locked = 1'b1;
        end else begin
            streaming = 1'b0;           // Halt, no error expected
            repeat (8) @(posedge clk);
            #2;
            streaming = 1'b1;
        end
    endtask

    // ==============================
    // One block on the wire
    // ==============================
    task automatic play_block(input row_t row);
        logic [7:0] b;
        int i;
        repeat (row.pre_len) shift_byte(8'hAA);
        shift_byte(8'h44);              // Sync mark
        shift_byte(8'h89);
        if (row.fault == F_SHORT) begin
            exp_err++;                  // Counted preamble is pre_len - 1
            exp_pre_err++;
            return;
        end
        exp_framed++;                   // Sync accepted, header follows
        shift_byte(8'hA1);
        chk0.queue_byte(row.hdr, 1'b1, 1'b0);
        if (exp_idx == 0) exp_seg_start++;
        shift_byte(row.hdr);
        for (i = 0; i < DATA_BYTES; i++) begin
            if (row.fault != F_NONE && i == row.fault_at) begin
                abort_block(row.fault);
                return;
            end
            seed = next_random(seed);
            b = seed[23:16];
            chk0.queue_byte(b, 1'b0, 1'b0);
            shift_byte(b);
        end
        chk0.await_ecc(row.ecc);
        for (i = 0; i < ECC_BYTES; i++) begin
            chk0.queue_byte(row.ecc[8*i +: 8], 1'b0, 1'b1);
            shift_byte(row.ecc[8*i +: 8]);
        end
        exp_good++;                     // Any header type counts
        if (exp_idx == BLOCKS_PER_SEG - 1) begin
            exp_idx = 0;
            exp_seg++;
            exp_seg_done++;
        end else begin
            exp_idx++;
        end
    endtask

    // ==============================
    // Main sequence and watchdog
    // ==============================
    initial begin
        int r;
        int n;
        reset_n        = 1'b0;
        enable         = 1'b1;
        streaming      = 1'b1;
        clear_counters = 1'b0;
        mfm_data       = 1'b0;
        mfm_clock      = 1'b0;
        dpll_locked    = 1'b1;
        load_table();
        wd_limit = 0;
        for (r = 0; r < NUM_ROWS; r++) begin
            // Sync, 0xA1, header, data, ECC and gap come to 521 bytes
            wd_limit += rows[r].reps * (rows[r].pre_len + 521) * 8;
        end
        wd_limit = wd_limit * 2 * 4 * 40;
        wd_armed = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        reset_n = 1'b1;
        shift_byte(8'h00);
        for (r = 0; r < NUM_ROWS; r++) begin
            for (n = 0; n < rows[r].reps; n++) begin
                play_block(rows[r]);
                shift_byte(8'h00);      // Inter-block gap
                shift_byte(8'h00);
            end
            chk0.audit_counters(exp_good, exp_seg, exp_err, exp_idx);
            chk0.strobe_totals(exp_pre_err, exp_sync_lost, exp_seg_start, exp_seg_done);
            chk0.frame_totals(exp_framed, exp_framed, exp_good);
        end
        clear_counters = 1'b1;          // Segment position is kept
        @(posedge clk);
        #2;
        clear_counters = 1'b0;
        @(posedge clk);
        #2;
        chk0.audit_counters(0, 0, 0, exp_idx);
        chk0.close_out();
        if (chk0.errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        wait (wd_armed);
        #(wd_limit);
        $display("Watchdog: no end of test after %0d ns, the run hung", wd_limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
src/qic_pkg.sv
src/qic_bit_front.sv
src/qic_block_framer.sv
src/qic_block_tally.sv
src/qic_streamer_top.sv
verif/qic_stream_checker.sv
verif/tb_qic_streamer.sv
